/* design/uart_bus_decoder.sv */
// Wishbone classic slave handshake and per-channel strobe decode
`include "uart_settings.svh"

module uart_bus_decoder
    import uart_reg_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [`UART_ADR_W-1:0]        wb_adr_i,
    output logic                          wb_ack_o,
    output logic [`UART_CHANNELS-1:0]     ctrl_we_o,
    output logic [`UART_CHANNELS-1:0]     tx_we_o,
    output logic [`UART_CHANNELS-1:0]     rx_re_o,
    output logic                          rd_stb_o,
    output logic [`UART_CHAN_W-1:0]       rd_chan_o,
    output uart_offset_e                  rd_ofs_o
);

    logic                   req;
    logic [`UART_CHAN_W-1:0] chan;
    uart_offset_e           ofs;

    // Accept only when no ack is pending
    assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign chan = wb_adr_i[`UART_ADR_W-1 -: `UART_CHAN_W];
    assign ofs  = uart_offset_e'(wb_adr_i[`UART_ADR_W-`UART_CHAN_W-1:0]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // ==================================================
    // Strobes act on the accepting edge
    // ==================================================
    always_comb begin
        ctrl_we_o = '0;
        tx_we_o   = '0;
        rx_re_o   = '0;
        for (int i = 0; i < `UART_CHANNELS; i++) begin
            if (req && chan == i) begin
                ctrl_we_o[i] = wb_we_i & (ofs == CTRL_OFS);
                tx_we_o[i]   = wb_we_i & (ofs == TXDATA_OFS);
                rx_re_o[i]   = ~wb_we_i & (ofs == RXDATA_OFS);
            end
        end
    end

    // Read mux captures on the same edge
    assign rd_stb_o  = req & ~wb_we_i;
    assign rd_chan_o = chan;
    assign rd_ofs_o  = ofs;

endmodule

/* design/uart_channel.sv */
// One UART channel: control register, transmitter and receiver
`include "uart_settings.svh"

module uart_channel
    import uart_reg_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       ctrl_we_i,
    input  logic       tx_we_i,
    input  logic       rx_re_i,
    input  logic [3:0] wb_sel_i,
    input  uart_word_u wb_dat_i,
    input  logic       uart_rx_i,
    output uart_word_u ctrl_o,
    output logic [3:0] status_o,
    output logic [7:0] rx_byte_o,
    output logic       uart_tx_o
);

    uart_word_u ctrl_q;
    logic       tx_full;
    logic       tx_empty;
    logic       rx_full;
    logic       rx_empty;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q               <= '0;
            ctrl_q.ctrl.baud_div <= `UART_DEFAULT_DIV;
        end else if (ctrl_we_i) begin
            if (wb_sel_i[0]) begin
                ctrl_q.ctrl.tx_en <= wb_dat_i.ctrl.tx_en;
                ctrl_q.ctrl.rx_en <= wb_dat_i.ctrl.rx_en;
            end
            // Divisor needs both upper byte lanes
            if (&wb_sel_i[3:2]) begin
                ctrl_q.ctrl.baud_div <= wb_dat_i.ctrl.baud_div;
            end
        end
    end

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (ctrl_q.ctrl.baud_div),
        .we_i       (tx_we_i),
        .stall_i    (~ctrl_q.ctrl.tx_en),
        .data_i     (wb_dat_i.data.byte_val),
        .full_o     (tx_full),
        .empty_o    (tx_empty),
        .tx_o       (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (ctrl_q.ctrl.baud_div),
        .re_i       (rx_re_i),
        .stall_i    (~ctrl_q.ctrl.rx_en),
        .rx_i       (uart_rx_i),
        .data_o     (rx_byte_o),
        .full_o     (rx_full),
        .empty_o    (rx_empty)
    );

    assign ctrl_o   = ctrl_q;
    assign status_o = {rx_empty, rx_full, tx_empty, tx_full};

endmodule

/* design/uart_line_pkg.sv */
// Serial line FSM state encodings
package uart_line_pkg;

    // Transmitter frame phases
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    // Receiver frame phases
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

endpackage

/* design/uart_read_mux.sv */
// Registered bus read data selection across channels
`include "uart_settings.svh"

module uart_read_mux
    import uart_reg_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                rd_stb_i,
    input  logic [`UART_CHAN_W-1:0]             rd_chan_i,
    input  uart_offset_e                        rd_ofs_i,
    input  uart_word_u [`UART_CHANNELS-1:0]     ctrl_i,
    input  logic [`UART_CHANNELS-1:0][3:0]      status_i,
    input  logic [`UART_CHANNELS-1:0][7:0]      rx_byte_i,
    output uart_word_u                          wb_dat_o
);

    uart_word_u rd_word;

    always_comb begin
        rd_word = '0;
        // Unpopulated channels and TXDATA read zero
        if (rd_chan_i < `UART_CHANNELS) begin
            case (rd_ofs_i)
                CTRL_OFS:   rd_word = ctrl_i[rd_chan_i];
                STATUS_OFS: rd_word.data.byte_val = {4'b0, status_i[rd_chan_i]};
                RXDATA_OFS: rd_word.data.byte_val = rx_byte_i[rd_chan_i];
                default:    rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_dat_o <= '0;
        end else if (rd_stb_i) begin
            wb_dat_o <= rd_word;
        end
    end

endmodule

/* design/uart_reg_pkg.sv */
// Register offsets and the bus word views
package uart_reg_pkg;

    // ==================================================
    // Register offsets within a channel
    // ==================================================
    typedef enum logic [3:0] {
        CTRL_OFS   = 4'h0,
        STATUS_OFS = 4'h4,
        RXDATA_OFS = 4'h8,
        TXDATA_OFS = 4'hC
    } uart_offset_e;

    // ==================================================
    // Bus word, control or data view
    // ==================================================
    typedef union packed {
        struct packed {
            logic [15:0] baud_div;
            logic [13:0] rsvd;
            logic        rx_en;
            logic        tx_en;
        } ctrl;
        struct packed {
            logic [23:0] rsvd;
            logic [7:0]  byte_val;
        } data;
    } uart_word_u;

endpackage

/* design/uart_rx.sv */
// Frame deserializer with mid-bit sampling and receive FIFO
`include "uart_settings.svh"

module uart_rx
    import uart_line_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [15:0] baud_div_i,
    input  logic        re_i,
    input  logic        stall_i,
    input  logic        rx_i,
    output logic [7:0]  data_o,
    output logic        full_o,
    output logic        empty_o
);

    localparam int AW = $clog2(`UART_FIFO_DEPTH);

    logic [7:0]  mem [`UART_FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        rx_s1;
    logic        rx_s2;
    logic        rx_d;
    rx_state_e   state;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;
    logic        bit_end;
    logic        half_bit;
    logic        push;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= rx_i;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    assign bit_end  = (cnt == baud_div_i - 16'd1);
    assign half_bit = (cnt == (baud_div_i >> 1));

    // ==================================================
    // Frame FSM
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= bit_end ? 16'd0 : cnt + 16'd1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!stall_i && rx_d && !rx_s2) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Confirm start at mid-bit, then count from the centre
                    if (half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s2 ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        shift   <= {rx_s2, shift[7:1]};
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Bad stop bit or full FIFO drops the byte
    assign push = (state == RX_STOP) && bit_end && rx_s2 && !full_o;

    // ==================================================
    // Receive FIFO
    // ==================================================
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign data_o  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= shift;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* design/uart_settings.svh */
// Build-time sizing for the UART peripheral
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Number of UART channels behind the bus port
`define UART_CHANNELS 2

// Entries per TX and RX FIFO, power of two
`define UART_FIFO_DEPTH 4

// Baud divisor loaded on reset
`define UART_DEFAULT_DIV 16'd434

// Address layout, channel in the upper bits
`define UART_ADR_W 6
`define UART_CHAN_W 2

`endif

/* design/uart_top.sv */
// Top level: bus decoder, channel array and read mux
`include "uart_settings.svh"

module uart_top
    import uart_reg_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [`UART_ADR_W-1:0]    wb_adr_i,
    input  logic [3:0]                wb_sel_i,
    input  logic [31:0]               wb_dat_i,
    output logic                      wb_ack_o,
    output logic [31:0]               wb_dat_o,
    input  logic [`UART_CHANNELS-1:0] uart_rx_i,
    output logic [`UART_CHANNELS-1:0] uart_tx_o
);

    logic [`UART_CHANNELS-1:0]       ctrl_we;
    logic [`UART_CHANNELS-1:0]       tx_we;
    logic [`UART_CHANNELS-1:0]       rx_re;
    logic                            rd_stb;
    logic [`UART_CHAN_W-1:0]         rd_chan;
    uart_offset_e                    rd_ofs;
    uart_word_u [`UART_CHANNELS-1:0] ctrl_word;
    logic [`UART_CHANNELS-1:0][3:0]  status;
    logic [`UART_CHANNELS-1:0][7:0]  rx_byte;

    uart_bus_decoder u_decoder (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_ack_o  (wb_ack_o),
        .ctrl_we_o (ctrl_we),
        .tx_we_o   (tx_we),
        .rx_re_o   (rx_re),
        .rd_stb_o  (rd_stb),
        .rd_chan_o (rd_chan),
        .rd_ofs_o  (rd_ofs)
    );

    for (genvar c = 0; c < `UART_CHANNELS; c++) begin : g_chan
        uart_channel u_channel (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .ctrl_we_i (ctrl_we[c]),
            .tx_we_i   (tx_we[c]),
            .rx_re_i   (rx_re[c]),
            .wb_sel_i  (wb_sel_i),
            .wb_dat_i  (wb_dat_i),
            .uart_rx_i (uart_rx_i[c]),
            .ctrl_o    (ctrl_word[c]),
            .status_o  (status[c]),
            .rx_byte_o (rx_byte[c]),
            .uart_tx_o (uart_tx_o[c])
        );
    end

    uart_read_mux u_read_mux (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_stb_i  (rd_stb),
        .rd_chan_i (rd_chan),
        .rd_ofs_i  (rd_ofs),
        .ctrl_i    (ctrl_word),
        .status_i  (status),
        .rx_byte_i (rx_byte),
        .wb_dat_o  (wb_dat_o)
    );

endmodule

/* design/uart_tx.sv */
// Transmit FIFO and frame serializer
`include "uart_settings.svh"

module uart_tx
    import uart_line_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [15:0] baud_div_i,
    input  logic        we_i,
    input  logic        stall_i,
    input  logic [7:0]  data_i,
    output logic        full_o,
    output logic        empty_o,
    output logic        tx_o
);

    localparam int AW = $clog2(`UART_FIFO_DEPTH);

    logic [7:0]  mem [`UART_FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    tx_state_e   state;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;
    logic        bit_end;

    // ==================================================
    // FIFO, extra pointer bit tells full from empty
    // ==================================================
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    always_ff @(posedge clk_i) begin
        if (we_i && !full_o) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
        end else if (we_i && !full_o) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ==================================================
    // Serializer
    // ==================================================
    assign bit_end = (cnt == baud_div_i - 16'd1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= TX_IDLE;
            rd_ptr  <= '0;
            cnt     <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            cnt <= bit_end ? 16'd0 : cnt + 16'd1;
            case (state)
                TX_IDLE: begin
                    tx_o <= 1'b1;
                    cnt  <= '0;
                    // Stall only blocks the next frame
                    if (!empty_o && !stall_i) begin
                        shift  <= mem[rd_ptr[AW-1:0]];
                        rd_ptr <= rd_ptr + 1'b1;
                        tx_o   <= 1'b0;
                        state  <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx_o    <= shift[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            shift   <= shift >> 1;
                            tx_o    <= shift[1];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* sim/uart_props.sv */
// Bus decoder handshake and strobe assertions for binding
`include "uart_settings.svh"

module uart_props
    import uart_reg_pkg::*;
(
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      cyc_i,
    input logic                      stb_i,
    input logic                      ack_i,
    input logic [`UART_CHANNELS-1:0] ctrl_we_i,
    input logic [`UART_CHANNELS-1:0] tx_we_i,
    input logic [`UART_CHANNELS-1:0] rx_re_i,
    input logic                      rd_stb_i
);

    int   assert_fails = 0;
    logic accepted;

    assign accepted = cyc_i & stb_i & ~ack_i;

    // ==================================================
    // Handshake
    // ==================================================
    ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
        else begin
            $error("ack high on two cycles in a row");
            assert_fails++;
        end

    ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> $past(accepted))
        else begin
            $error("ack without a request on the previous cycle");
            assert_fails++;
        end

    // ==================================================
    // Strobes
    // ==================================================
    strobe_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(ctrl_we_i) && $onehot0(tx_we_i) && $onehot0(rx_re_i))
        else begin
            $error("strobe vector with more than one channel set");
            assert_fails++;
        end

    strobe_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        (|ctrl_we_i || |tx_we_i || |rx_re_i || rd_stb_i) |-> accepted)
        else begin
            $error("strobe issued without an accepted request");
            assert_fails++;
        end

endmodule

bind uart_bus_decoder uart_props u_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .ack_i     (wb_ack_o),
    .ctrl_we_i (ctrl_we_o),
    .tx_we_i   (tx_we_o),
    .rx_re_i   (rx_re_o),
    .rd_stb_i  (rd_stb_o)
);

/* sim/uart_tb.sv */
// Table-driven testbench with serial loopback, compare tasks and watchdog
`include "uart_settings.svh"

module uart_tb
    import uart_reg_pkg::*;
();

    localparam int     LOOP_DIV     = 8;
    localparam int     FRAME_CYCLES = 10 * LOOP_DIV;
    localparam longint POLL_LIMIT   = 20 * FRAME_CYCLES * 20;
    localparam int     RX_EMPTY_BIT = 3;

    typedef enum {OP_WRITE, OP_RD_CTRL, OP_RD_BYTE, OP_POLL_RX, OP_IDLE} op_e;

    typedef struct {
        string        name;
        op_e          op;
        int           chan;
        uart_offset_e ofs;
        logic [3:0]   sel;
        uart_word_u   data;
        uart_word_u   exp_val;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`UART_ADR_W-1:0]    wb_adr;
    logic [3:0]                wb_sel;
    uart_word_u                wb_dat;
    logic                      wb_ack;
    uart_word_u                wb_rdat;
    logic [`UART_CHANNELS-1:0] tx_line;
    logic [`UART_CHANNELS-1:0] rx_line;
    row_t                      rows[$];
    logic [7:0]                pending[$];
    logic [31:0]               rng;
    longint                    wd_limit;
    bit                        table_ready;
    uart_word_u                rd_word;

    // Channel 0 TX feeds channel 1 RX and back
    assign rx_line = {tx_line[0], tx_line[1]};

    uart_top u_uart_top (
        .clk_i     (clk),
        .rst_i     (rst),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_sel_i  (wb_sel),
        .wb_dat_i  (wb_dat),
        .wb_ack_o  (wb_ack),
        .wb_dat_o  (wb_rdat),
        .uart_rx_i (rx_line),
        .uart_tx_o (tx_line)
    );

    always #10 clk = ~clk;

    // ==================================================
    // Expected value builders
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic uart_word_u ctrl_val(input logic [15:0] div, input logic rx_en,
                                            input logic tx_en);
        uart_word_u w;
        w = '0;
        w.ctrl.baud_div = div;
        w.ctrl.rx_en    = rx_en;
        w.ctrl.tx_en    = tx_en;
        return w;
    endfunction

    function automatic uart_word_u byte_word(input logic [7:0] b);
        uart_word_u w;
        w = '0;
        w.data.byte_val = b;
        return w;
    endfunction

    // Nibble order is rx_empty, rx_full, tx_empty, tx_full
    function automatic uart_word_u status_word(input logic rx_empty, input logic rx_full,
                                               input logic tx_empty, input logic tx_full);
        return byte_word({4'b0, rx_empty, rx_full, tx_empty, tx_full});
    endfunction

    // ==================================================
    // Stimulus table
    // ==================================================
    function automatic void add_row(input string name, input op_e op, input int chan,
                                    input uart_offset_e ofs, input logic [3:0] sel,
                                    input uart_word_u data, input uart_word_u exp_val);
        row_t r;
        r = '{name, op, chan, ofs, sel, data, exp_val};
        rows.push_back(r);
    endfunction

    // Random bytes into TXDATA, queued for the far receiver when kept
    function automatic void add_sends(input string tag, input int src, input int n,
                                      input bit keep);
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            add_row($sformatf("%s send %0d", tag, i), OP_WRITE, src, TXDATA_OFS, 4'h1,
                    byte_word(rng[7:0]), '0);
            if (keep) begin
                pending.push_back(rng[7:0]);
            end
        end
    endfunction

    function automatic void add_receives(input string tag, input int dst, input int n);
        for (int i = 0; i < n; i++) begin
            add_row($sformatf("%s poll %0d", tag, i), OP_POLL_RX, dst, STATUS_OFS, 4'hF,
                    '0, '0);
            add_row($sformatf("%s data %0d", tag, i), OP_RD_BYTE, dst, RXDATA_OFS, 4'hF,
                    '0, byte_word(pending.pop_front()));
        end
    endfunction

    function automatic void fill_table();
        uart_word_u idle_st;
        uart_word_u full_st;
        idle_st = status_word(1'b1, 1'b0, 1'b1, 1'b0);
        full_st = status_word(1'b1, 1'b0, 1'b0, 1'b1);
        rng = 32'd77499;
        add_row("reset ctrl ch0", OP_RD_CTRL, 0, CTRL_OFS, 4'hF, '0,
                ctrl_val(`UART_DEFAULT_DIV, 1'b0, 1'b0));
        add_row("reset ctrl ch1", OP_RD_CTRL, 1, CTRL_OFS, 4'hF, '0,
                ctrl_val(`UART_DEFAULT_DIV, 1'b0, 1'b0));
        add_row("reset status ch0", OP_RD_BYTE, 0, STATUS_OFS, 4'hF, '0, idle_st);
        add_row("reset status ch1", OP_RD_BYTE, 1, STATUS_OFS, 4'hF, '0, idle_st);
        add_row("unused ch3", OP_RD_CTRL, 3, CTRL_OFS, 4'hF, '0, '0);
        // Lane 0 moves the enables, lanes 3:2 the divisor
        add_row("enables only", OP_WRITE, 0, CTRL_OFS, 4'h1, ctrl_val(LOOP_DIV, 1, 1), '0);
        add_row("enables only rb", OP_RD_CTRL, 0, CTRL_OFS, 4'hF, '0,
                ctrl_val(`UART_DEFAULT_DIV, 1'b1, 1'b1));
        add_row("divisor only", OP_WRITE, 0, CTRL_OFS, 4'hC, ctrl_val(LOOP_DIV, 0, 0), '0);
        add_row("divisor only rb", OP_RD_CTRL, 0, CTRL_OFS, 4'hF, '0, ctrl_val(LOOP_DIV, 1, 1));
        add_row("full word ch1", OP_WRITE, 1, CTRL_OFS, 4'hF, ctrl_val(LOOP_DIV, 1, 1), '0);
        add_row("full word ch1 rb", OP_RD_CTRL, 1, CTRL_OFS, 4'hF, '0, ctrl_val(LOOP_DIV, 1, 1));
        add_sends("ch0 to ch1", 0, 3, 1'b1);
        add_receives("ch0 to ch1", 1, 3);
        add_sends("ch1 to ch0", 1, 2, 1'b1);
        add_receives("ch1 to ch0", 0, 2);
        add_row("loop status ch1", OP_RD_BYTE, 1, STATUS_OFS, 4'hF, '0, idle_st);
        add_row("loop status ch0", OP_RD_BYTE, 0, STATUS_OFS, 4'hF, '0, idle_st);
        // Stalled transmitter, one byte past full is lost
        add_row("tx off ch0", OP_WRITE, 0, CTRL_OFS, 4'h1, ctrl_val(0, 1, 0), '0);
        add_sends("stall", 0, `UART_FIFO_DEPTH, 1'b1);
        add_row("stall full", OP_RD_BYTE, 0, STATUS_OFS, 4'hF, '0, full_st);
        add_sends("overflow", 0, 1, 1'b0);
        add_row("overflow full", OP_RD_BYTE, 0, STATUS_OFS, 4'hF, '0, full_st);
        add_row("tx on ch0", OP_WRITE, 0, CTRL_OFS, 4'h1, ctrl_val(0, 1, 1), '0);
        add_receives("stall", 1, `UART_FIFO_DEPTH);
        add_row("overflow gap", OP_IDLE, 0, CTRL_OFS, 4'h0, 3 * FRAME_CYCLES, '0);
        add_row("drained ch0", OP_RD_BYTE, 0, STATUS_OFS, 4'hF, '0, idle_st);
        add_row("nothing extra ch1", OP_RD_BYTE, 1, STATUS_OFS, 4'hF, '0, idle_st);
        // Receiver off, frame goes by unseen
        add_row("rx off ch1", OP_WRITE, 1, CTRL_OFS, 4'h1, ctrl_val(0, 0, 1), '0);
        add_sends("ignored", 0, 1, 1'b0);
        add_row("ignored gap", OP_IDLE, 0, CTRL_OFS, 4'h0, FRAME_CYCLES + 40, '0);
        add_row("ignored status", OP_RD_BYTE, 1, STATUS_OFS, 4'hF, '0, idle_st);
        add_row("rx on ch1", OP_WRITE, 1, CTRL_OFS, 4'h1, ctrl_val(0, 1, 1), '0);
        add_sends("reenabled", 0, 1, 1'b1);
        add_receives("reenabled", 1, 1);
        add_row("final status ch1", OP_RD_BYTE, 1, STATUS_OFS, 4'hF, '0, idle_st);
    endfunction

    // ==================================================
    // Bus access and checks
    // ==================================================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_ctrl(input string name, input uart_word_u exp_val,
                              input uart_word_u act);
        if (act.ctrl !== exp_val.ctrl) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h", name,
                                     exp_val.ctrl, act.ctrl));
        end
    endtask

    task automatic check_byte(input string name, input uart_word_u exp_val,
                              input uart_word_u act);
        if (act.data.byte_val !== exp_val.data.byte_val) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h", name,
                                     exp_val.data.byte_val, act.data.byte_val));
        end
    endtask

    task automatic bus_access(input logic we, input int chan, input uart_offset_e ofs,
                              input logic [3:0] sel, input uart_word_u wdata,
                              output uart_word_u rdata);
        bit acked;
        acked = 1'b0;
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = {chan[`UART_CHAN_W-1:0], ofs};
        wb_sel = sel;
        wb_dat = wdata;
        for (int n = 0; n < 4 && !acked; n++) begin
            @(posedge clk);
            #1;
            acked = wb_ack;
        end
        if (!acked) begin
            report_failure("no acknowledge from slave");
        end
        rdata = wb_rdat;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic poll_rx(input string name, input int chan);
        uart_word_u st;
        longint     t_start;
        t_start = $time;
        bus_access(1'b0, chan, STATUS_OFS, 4'hF, '0, st);
        while (st.data.byte_val[RX_EMPTY_BIT]) begin
            if ($time - t_start > POLL_LIMIT) begin
                report_failure($sformatf("%s: receive byte never arrived", name));
            end
            bus_access(1'b0, chan, STATUS_OFS, 4'hF, '0, st);
        end
    endtask

    // Watchdog sized from the table once it is built
    initial begin
        wait (table_ready);
        #(wd_limit);
        report_failure("watchdog expired before all rows completed");
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_sel      = '0;
        wb_dat      = '0;
        table_ready = 1'b0;
        fill_table();
        wd_limit    = longint'(rows.size()) * (12 * 10 * `UART_DEFAULT_DIV + 40) * 20;
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WRITE: begin
                    bus_access(1'b1, rows[i].chan, rows[i].ofs, rows[i].sel, rows[i].data,
                               rd_word);
                end
                OP_RD_CTRL: begin
                    bus_access(1'b0, rows[i].chan, rows[i].ofs, rows[i].sel, '0, rd_word);
                    check_ctrl(rows[i].name, rows[i].exp_val, rd_word);
                end
                OP_RD_BYTE: begin
                    bus_access(1'b0, rows[i].chan, rows[i].ofs, rows[i].sel, '0, rd_word);
                    check_byte(rows[i].name, rows[i].exp_val, rd_word);
                end
                OP_POLL_RX: begin
                    poll_rx(rows[i].name, rows[i].chan);
                end
                OP_IDLE: begin
                    repeat (int'(rows[i].data)) @(posedge clk);
                end
            endcase
        end
        if (u_uart_top.u_decoder.u_props.assert_fails == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure("bus protocol assertion failed during the run");
        end
    end

endmodule

/* src.f */
+incdir+design
design/uart_reg_pkg.sv
design/uart_line_pkg.sv
design/uart_bus_decoder.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_channel.sv
design/uart_read_mux.sv
design/uart_top.sv
sim/uart_props.sv
sim/uart_tb.sv
